/* Bender.yml */
package:
  name: ifu_fetch

sources:
  # RTL in compile order
  - verilog/fe_bus_pkg.sv
  - verilog/rv_instr_pkg.sv
  - verilog/fetch_stream_if.sv
  - verilog/fetch_queue.sv
  - verilog/fetch_request.sv
  - verilog/instr_assembly.sv
  - verilog/predecode.sv
  - verilog/ifu_top.sv
  # testbench
  - target: test
    files:
      - test/tb_ifu_mem.sv
      - test/tb_ifu.sv

/* flist.f */
verilog/fe_bus_pkg.sv
verilog/rv_instr_pkg.sv
verilog/fetch_stream_if.sv
verilog/fetch_queue.sv
verilog/fetch_request.sv
verilog/instr_assembly.sv
verilog/predecode.sv
verilog/ifu_top.sv
test/tb_ifu_mem.sv
test/tb_ifu.sv

/* test/tb_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifu;

	localparam int half_period = 20;
	localparam logic [31:0] seed_init = 32'ha1c9_17c1;
	// cycles without a consumed instruction before the run gives up
	localparam int idle_limit = 200;

	logic        clk;
	logic        rst_n;
	logic [31:0] mem_addr;
	logic        mem_size;
	logic        mem_addr_vld;
	logic        mem_addr_rdy;
	logic [31:0] mem_data;
	logic        mem_data_vld;
	logic [31:0] ext_jump_target;
	logic        ext_jump_vld;
	logic        ext_jump_rdy;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic        instr_vld;
	logic        instr_is_c;
	logic        instr_stall;

	integer seed;
	int errors = 0;
	int checks = 0;
	int bus_errors = 0;
	logic timed_out = 1'b0;
	// reference model and redirect state
	logic [31:0] model_pc = fe_bus_pkg::reset_vector;
	logic ext_taken = 1'b0;
	// bus monitor state
	int in_flight = 0;
	logic addr_held = 1'b0;
	logic [31:0] held_addr = '0;
	logic held_size = 1'b0;
	// what the stream went through
	int straddled = 0;
	int compressed = 0;
	int jumps = 0;
	int odd_redirects = 0;
	int stalled = 0;
	int holds = 0;

	ifu_top dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_vld    (mem_data_vld),
		.ext_jump_target (ext_jump_target),
		.ext_jump_vld    (ext_jump_vld),
		.ext_jump_rdy    (ext_jump_rdy),
		.instr           (instr),
		.instr_pc        (instr_pc),
		.instr_vld       (instr_vld),
		.instr_is_c      (instr_is_c),
		.instr_stall     (instr_stall)
	);

	tb_ifu_mem #(
		.seed_init (seed_init)
	) mem_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data     (mem_data),
		.mem_data_vld (mem_data_vld)
	);

	always begin
		#half_period clk = ~clk;
	end

	// ==============================
	// helpers
	// ==============================

	function automatic int percent_roll();
		logic [31:0] r;
		r = $random(seed);
		percent_roll = r % 100;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// the instruction at pc and the pc after it, straight from the ISA rules
	task automatic predict(input logic [31:0] pc, output logic [31:0] ins, output logic is_c,
		output logic [31:0] nxt, output logic jump);
		rv_instr_pkg::instr_u u;
		logic [31:0] lo_word;
		logic [31:0] hi_word;
		logic [15:0] lo;
		logic [31:0] off;
		lo_word = mem_i.word_at(pc);
		hi_word = mem_i.word_at(pc + 32'd2);
		lo = pc[1] ? lo_word[31:16] : lo_word[15:0];
		is_c = (lo[1:0] & rv_instr_pkg::instr_is_32) != rv_instr_pkg::instr_is_32;
		ins = is_c ? {16'h0000, lo} : {pc[1] ? hi_word[15:0] : hi_word[31:16], lo};
		u = ins;
		if (is_c) begin
			jump = {u.c.lower.funct3, u.c.lower.op} == rv_instr_pkg::c_funct_j;
			off = {{20{lo[12]}}, lo[12], lo[8], lo[10:9], lo[6], lo[7], lo[2], lo[11],
				lo[5:3], 1'b0};
		end else begin
			jump = u.j.opcode == rv_instr_pkg::opc_jal;
			off = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		nxt = jump ? pc + off : pc + (is_c ? 32'd2 : 32'd4);
	endtask

	task automatic watch_bus();
		int e0;
		e0 = errors;
		// a held address phase repeats unchanged
		if (addr_held) begin
			compare_value("mem_addr_vld", mem_addr_vld, 32'd1);
			compare_value("mem_addr", mem_addr, held_addr);
			compare_value("mem_size", mem_size, held_size);
		end
		if (mem_data_vld) begin
			if (in_flight == 0) begin
				errors++;
				$display("Error at time %0t: bus data came back with no fetch in flight", $time);
			end else begin
				in_flight--;
			end
		end
		if (mem_addr_vld && mem_addr_rdy) begin
			in_flight++;
		end
		if (in_flight > 2) begin
			errors++;
			$display("Error at time %0t: more than two fetches wait for data", $time);
		end
		addr_held = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
		held_size = mem_size;
		if (addr_held) begin
			holds++;
		end
		bus_errors += errors - e0;
	endtask

	// drives on the rising edge and checks in the middle of the cycle
	task automatic run_phase(input int n_instr, input int stall_pct, input int jump_pct);
		int done;
		int idle;
		logic [31:0] r;
		logic [31:0] exp_instr;
		logic [31:0] next_pc;
		logic exp_is_c;
		logic is_jump;
		done = 0;
		idle = 0;
		while (done < n_instr && !timed_out) begin
			@(posedge clk);
			// a raised redirect stays up until it is taken
			if (!ext_jump_vld || ext_taken) begin
				r = $random(seed);
				ext_jump_vld <= percent_roll() < jump_pct;
				ext_jump_target <= {20'h0_0000, r[11:1], 1'b0};
				ext_taken = 1'b0;
			end
			instr_stall <= percent_roll() < stall_pct;
			@(negedge clk);
			watch_bus();
			idle++;
			if (instr_vld) begin
				predict(model_pc, exp_instr, exp_is_c, next_pc, is_jump);
				compare_value("instr_pc", instr_pc, model_pc);
				compare_value("instr", instr, exp_instr);
				compare_value("instr_is_c", instr_is_c, exp_is_c);
				// a jump goes out only together with its own redirect
				if (is_jump) begin
					compare_value("ext_jump_vld", ext_jump_vld, 32'd0);
					compare_value("ext_jump_rdy", ext_jump_rdy, 32'd1);
				end
				if (instr_stall) begin
					stalled++;
				end else begin
					straddled += !exp_is_c && model_pc[1];
					compressed += exp_is_c;
					jumps += is_jump;
					model_pc = next_pc;
					done++;
					idle = 0;
				end
			end
			// the old stream ends where execute's redirect is taken
			if (ext_jump_vld && ext_jump_rdy) begin
				compare_value("instr_vld", instr_vld, 32'd0);
				model_pc = ext_jump_target;
				ext_taken = 1'b1;
				odd_redirects += ext_jump_target[1];
			end
			if (idle >= idle_limit) begin
				errors++;
				timed_out = 1'b1;
				$display("Error at time %0t: no instruction consumed for %0d cycles",
					$time, idle_limit);
			end
		end
	endtask

	task automatic print_test(input int num, input string name, input int fails);
		$display("test %0d %s: %s", num, name, fails == 0 ? "ok" : "failed");
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		int e0;
		clk = 1'b0;
		rst_n = 1'b0;
		ext_jump_target = '0;
		ext_jump_vld = 1'b0;
		instr_stall = 1'b0;
		seed = seed_init;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		e0 = errors;
		run_phase(2000, 0, 0);
		print_test(1, "stream from reset", errors - e0);
		if (straddled == 0 || compressed == 0) begin
			errors++;
			$display("Error: no 16-bit or no straddling 32-bit instruction was seen");
		end
		print_test(2, "mixed lengths across word boundaries", errors - e0);
		if (jumps == 0) begin
			errors++;
			$display("Error: no JAL or C.J was followed");
		end
		print_test(3, "JAL and C.J followed", errors - e0);

		e0 = errors;
		run_phase(1000, 0, 3);
		if (odd_redirects == 0) begin
			errors++;
			$display("Error: no redirect to an odd halfword was taken");
		end
		print_test(4, "external redirects", errors - e0);

		e0 = errors;
		run_phase(1000, 30, 0);
		if (stalled == 0) begin
			errors++;
			$display("Error: no instruction was held by a stall");
		end
		print_test(5, "stalls toward execute", errors - e0);

		// bus rules are watched through all phases
		if (holds == 0) begin
			errors++;
			bus_errors++;
			$display("Error: no address phase was ever held");
		end
		print_test(6, "bus address phase rules", bus_errors);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_ifu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_mem #(
	parameter logic [31:0] seed_init = 32'h0000_0001
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] mem_addr,
	input  logic        mem_addr_vld,
	output logic        mem_addr_rdy,
	output logic [31:0] mem_data,
	output logic        mem_data_vld
);

	integer seed;

	// ==============================
	// memory contents
	// ==============================

	// C.J halfword that jumps forward by a small even offset
	function automatic logic [15:0] cj_hw(input logic [4:0] n);
		logic [11:0] o;
		o = {5'h00, {1'b0, n} + 6'd1, 1'b0};
		cj_hw = {rv_instr_pkg::c_funct_j[4:2], o[11], o[4], o[9:8], o[10], o[6], o[7],
			o[3:1], o[5], rv_instr_pkg::c_funct_j[1:0]};
	endfunction

	// accidental JAL opcodes turn into JALR which fetch does not follow
	// and every C.J goes forward by at least 32 bytes so the stream never loops
	function automatic logic [15:0] tidy(input logic [15:0] hw);
		logic [15:0] t;
		t = hw;
		if (t[6:0] == rv_instr_pkg::opc_jal) begin
			t[3] = 1'b0;
		end
		if ({t[15:13], t[1:0]} == rv_instr_pkg::c_funct_j) begin
			t[12] = 1'b0;
			t[2] = 1'b1;
		end
		tidy = t;
	endfunction

	// the word at an address is a fixed hash of the whole word address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [31:0] wa;
		logic [31:0] h;
		logic [31:0] g;
		logic [20:0] jo;
		wa = {2'b00, addr[31:2]};
		h = wa * 32'h9e37_79b1 + 32'h7f4a_7c15;
		h = h ^ (h >> 15);
		h = h * 32'h2c1b_3c6d;
		h = h ^ (h >> 12);
		g = h * 32'h85eb_ca6b ^ (h >> 13);
		if (g[3:0] == 4'h0) begin
			// about one word in sixteen is a JAL with a short forward offset
			jo = {14'h0000, {1'b0, g[8:4]} + 6'd1, 1'b0};
			word_at = {jo[20], jo[10:1], jo[11], jo[19:12], g[13:9], rv_instr_pkg::opc_jal};
			word_at[31:16] = tidy(word_at[31:16]);
		end else begin
			// each halfword is a C.J about one time in eight
			word_at[15:0] = tidy(g[6:4] == 3'd0 ? cj_hw(g[12:8]) : h[15:0]);
			word_at[31:16] = tidy(g[18:16] == 3'd0 ? cj_hw(g[23:19]) : h[31:16]);
		end
	endfunction

	// ==============================
	// bus responder
	// ==============================

	initial begin
		seed = seed_init;
		mem_addr_rdy = 1'b0;
		mem_data = '0;
		mem_data_vld = 1'b0;
	end

	// data follows one cycle after the address is taken
	// a half fetch gets the whole word and the yard picks its upper half
	always @(posedge clk or negedge rst_n) begin : respond
		logic [31:0] r;
		if (!rst_n) begin
			mem_addr_rdy <= 1'b0;
			mem_data <= '0;
			mem_data_vld <= 1'b0;
		end else begin
			r = $random(seed);
			mem_data_vld <= mem_addr_vld && mem_addr_rdy;
			if (mem_addr_vld && mem_addr_rdy) begin
				mem_data <= word_at(mem_addr);
			end
			// ready about three cycles in four
			mem_addr_rdy <= r[1:0] != 2'b00;
		end
	end

endmodule

`default_nettype wire

/* verilog/fe_bus_pkg.sv */
`default_nettype none

// ==============================
// fetch bus and fetch queue
// ==============================
package fe_bus_pkg;

	// byte address width of the instruction bus
	localparam int addr_w = 32;

	// the data bus is always one 32-bit word wide
	localparam int data_w = 32;

	// the assembly yard works in halfwords
	// which is the granule of the compressed extension
	localparam int hw_w = 16;

	// default number of bus words the fetch queue can hold
	// must be a power of two and at least 2
	localparam int fifo_depth = 2;

	// first fetch address after reset
	localparam logic [addr_w-1:0] reset_vector = 32'h0000_0000;

endpackage

`default_nettype wire

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
	parameter int depth = fe_bus_pkg::fifo_depth
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [fe_bus_pkg::data_w-1:0] mem_data,
	input  logic                          mem_data_vld,
	fetch_stream_if.queue                 fs
);

	// pointers carry one wrap bit above the index
	localparam int ptr_w = $clog2(depth) + 1;

	logic [fe_bus_pkg::data_w-1:0] mem [depth];
	logic [ptr_w-1:0] wptr;
	logic [ptr_w-1:0] rptr;
	logic [ptr_w-1:0] level;
	logic push;
	logic pop;

	assign level = wptr - rptr;
	assign fs.queue_empty = wptr == rptr;
	// full when only the wrap bits differ
	assign fs.queue_full = (wptr ^ rptr) == {1'b1, {(ptr_w - 1){1'b0}}};
	assign fs.queue_almost_full = level == ptr_w'(depth - 1);

	// a word that goes straight past an empty queue into the yard is not stored
	// and words of a discarded stream are dropped on arrival
	assign push = mem_data_vld && !fs.flush_pending && !(fs.must_refill && fs.queue_empty);
	assign pop = fs.must_refill && !fs.queue_empty;

	// first word fall through
	assign fs.fetch_data = fs.queue_empty ? mem_data : mem[rptr[ptr_w-2:0]];
	assign fs.fetch_data_vld = !fs.queue_empty || (mem_data_vld && !fs.flush_pending);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			// a flush empties the queue in one step
			// including a word written in the same cycle
			if (fs.flush) begin
				rptr <= wptr + ptr_w'(push);
			end else if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wptr[ptr_w-2:0]] <= mem_data;
		end
	end

	// the request side must stop issuing early enough
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && fs.queue_full));

endmodule

`default_nettype wire

/* verilog/fetch_request.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_request (
	input  logic                          clk,
	input  logic                          rst_n,
	output logic [fe_bus_pkg::addr_w-1:0] mem_addr,
	output logic                          mem_size,
	output logic                          mem_addr_vld,
	input  logic                          mem_addr_rdy,
	input  logic                          mem_data_vld,
	input  logic [fe_bus_pkg::addr_w-1:0] ext_jump_target,
	input  logic                          ext_jump_vld,
	input  logic [fe_bus_pkg::addr_w-1:0] pd_jump_target,
	input  logic                          pd_jump_vld,
	output logic                          jump_rdy,
	fetch_stream_if.request               fs
);

	logic [fe_bus_pkg::addr_w-1:0] jump_target;
	logic [fe_bus_pkg::addr_w-1:0] fetch_addr;
	logic jump_vld;
	logic jump_now;
	logic unaligned_now;
	logic mem_addr_hold;
	logic [1:0] pending;
	logic [1:0] flush_ctr;
	logic fetch_stall;
	logic unaligned_aph;
	logic unaligned_dph;

	// ==============================
	// redirect merge
	// ==============================

	// the execute stage wins over a jump found by predecode
	assign jump_vld = ext_jump_vld || pd_jump_vld;
	assign jump_target = ext_jump_vld ? ext_jump_target : pd_jump_target;

	// a held address must not change so redirects wait for it
	assign jump_rdy = !mem_addr_hold;
	assign jump_now = jump_vld && jump_rdy;
	assign unaligned_now = jump_now && jump_target[1];

	assign fs.flush = jump_now;
	assign fs.flush_pending = |flush_ctr;
	assign fs.unaligned_dph = unaligned_dph;

	// ==============================
	// bus bookkeeping
	// ==============================

	// a fetch counts as pending from its first address cycle
	// registered levels only here to keep ready off the address path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_addr_hold <= 1'b0;
			pending <= 2'd0;
			flush_ctr <= 2'd0;
		end else begin
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending <= pending + 2'(mem_addr_vld && !mem_addr_hold) - 2'(mem_data_vld);
			// every fetch still in flight at a redirect returns stale data
			if (jump_now) begin
				flush_ctr <= pending - 2'(mem_data_vld);
			end else if (|flush_ctr && mem_data_vld) begin
				flush_ctr <= flush_ctr - 1'b1;
			end
		end
	end

	// fetch address runs ahead of the PC in whole words
	// and steps past a target that goes out in the redirect cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= fe_bus_pkg::reset_vector;
		end else if (jump_now) begin
			fetch_addr <= {jump_target[fe_bus_pkg::addr_w-1:2] + 30'(mem_addr_rdy), 2'b00};
		end else if (mem_addr_vld && mem_addr_rdy) begin
			fetch_addr <= fetch_addr + 32'd4;
		end
	end

	// unaligned targets fetch their upper halfword alone
	// aph keeps that size on a held address and dph tells the yard where to start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unaligned_aph <= 1'b0;
			unaligned_dph <= 1'b0;
		end else begin
			if (mem_addr_rdy) begin
				unaligned_aph <= 1'b0;
			end
			if (mem_data_vld && !fs.flush_pending) begin
				unaligned_dph <= 1'b0;
			end
			if (unaligned_now) begin
				unaligned_aph <= !mem_addr_rdy;
				unaligned_dph <= 1'b1;
			end
		end
	end

	// never more in flight than the queue can take with no back-pressure
	assign fetch_stall = fs.queue_full
		|| (fs.queue_almost_full && |pending)
		|| pending > 2'd1;

	// address phase in priority order
	always_comb begin
		mem_addr = '0;
		mem_addr_vld = 1'b1;
		mem_size = 1'b1;
		if (mem_addr_hold) begin
			mem_addr = {fetch_addr[fe_bus_pkg::addr_w-1:2], unaligned_aph, 1'b0};
			mem_size = !unaligned_aph;
		end else if (jump_vld) begin
			mem_addr = jump_target;
			mem_size = !unaligned_now;
		end else if (!fetch_stall) begin
			mem_addr = fetch_addr;
		end else begin
			mem_addr_vld = 1'b0;
		end
	end

	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n) pending < 2'd3);
	a_no_stray_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_data_vld |-> pending != 2'd0);

endmodule

`default_nettype wire

/* verilog/fetch_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// carries fetched words and flush state between request side, queue and yard
interface fetch_stream_if;

	// request side state
	logic flush;
	logic flush_pending;
	logic unaligned_dph;

	// queue head or bypassed bus word
	logic [fe_bus_pkg::data_w-1:0] fetch_data;
	logic fetch_data_vld;

	// queue levels
	logic queue_full;
	logic queue_almost_full;
	logic queue_empty;

	// the yard consumes a fresh word this cycle
	logic must_refill;

	modport request (
		output flush, flush_pending, unaligned_dph,
		input  queue_full, queue_almost_full, queue_empty
	);

	modport queue (
		input  flush, flush_pending, must_refill,
		output fetch_data, fetch_data_vld, queue_full, queue_almost_full, queue_empty
	);

	modport assembly (
		input  flush, flush_pending, unaligned_dph, fetch_data, fetch_data_vld,
		output must_refill
	);

endinterface

`default_nettype wire

/* verilog/ifu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
	input  logic                          clk,
	input  logic                          rst_n,
	output logic [fe_bus_pkg::addr_w-1:0] mem_addr,
	output logic                          mem_size,
	output logic                          mem_addr_vld,
	input  logic                          mem_addr_rdy,
	input  logic [fe_bus_pkg::data_w-1:0] mem_data,
	input  logic                          mem_data_vld,
	input  logic [fe_bus_pkg::addr_w-1:0] ext_jump_target,
	input  logic                          ext_jump_vld,
	output logic                          ext_jump_rdy,
	output logic [31:0]                   instr,
	output logic [31:0]                   instr_pc,
	output logic                          instr_vld,
	output logic                          instr_is_c,
	input  logic                          instr_stall
);

	logic [31:0] cir;
	logic [1:0] cir_vld;
	logic [1:0] cir_use;
	logic [31:0] pd_jump_target;
	logic pd_jump_vld;

	fetch_stream_if fs ();

	fetch_queue u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_data     (mem_data),
		.mem_data_vld (mem_data_vld),
		.fs           (fs.queue)
	);

	// one ready level serves both redirect sources
	fetch_request u_request (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.ext_jump_target (ext_jump_target),
		.ext_jump_vld    (ext_jump_vld),
		.pd_jump_target  (pd_jump_target),
		.pd_jump_vld     (pd_jump_vld),
		.jump_rdy        (ext_jump_rdy),
		.fs              (fs.request)
	);

	instr_assembly u_yard (
		.clk     (clk),
		.rst_n   (rst_n),
		.cir_use (cir_use),
		.cir     (cir),
		.cir_vld (cir_vld),
		.fs      (fs.assembly)
	);

	predecode u_predecode (
		.clk             (clk),
		.rst_n           (rst_n),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.ext_jump_target (ext_jump_target),
		.ext_jump_vld    (ext_jump_vld),
		.jump_rdy        (ext_jump_rdy),
		.pd_jump_target  (pd_jump_target),
		.pd_jump_vld     (pd_jump_vld),
		.instr           (instr),
		.instr_pc        (instr_pc),
		.instr_vld       (instr_vld),
		.instr_is_c      (instr_is_c),
		.instr_stall     (instr_stall)
	);

endmodule

`default_nettype wire

/* verilog/instr_assembly.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_assembly (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [1:0]        cir_use,
	output logic [31:0]       cir,
	output logic [1:0]        cir_vld,
	fetch_stream_if.assembly  fs
);

	localparam int hw_w = fe_bus_pkg::hw_w;

	// number of valid halfwords in hwbuf and cir together
	logic [1:0] buf_level;
	logic [1:0] level_no_fetch;
	logic [1:0] buf_level_next;
	logic [hw_w-1:0] hwbuf;
	logic [3*hw_w-1:0] shifted;
	logic [3*hw_w-1:0] merged;
	logic [fe_bus_pkg::data_w-1:0] word;

	assign word = fs.fetch_data;

	// ==============================
	// shift and overlay
	// ==============================

	// move leftover halfwords down over what predecode takes
	// slots that fresh data overwrites are filled with whatever is cheapest
	always_comb begin
		if (cir_use[1]) begin
			shifted = {hwbuf, cir[hw_w +: hw_w], hwbuf};
		end else if (cir_use[0]) begin
			shifted = {hwbuf, hwbuf, cir[hw_w +: hw_w]};
		end else begin
			shifted = {hwbuf, cir};
		end
	end

	assign level_no_fetch = buf_level - cir_use;

	// with fewer than two halfwords left the yard takes a word now
	assign fs.must_refill = !level_no_fetch[1];

	// put the fresh word right above the leftover halfwords
	// after an unaligned jump only its upper half is an instruction
	always_comb begin
		if (fs.unaligned_dph) begin
			merged = {shifted[hw_w +: 2*hw_w], word[hw_w +: hw_w]};
		end else if (level_no_fetch[1]) begin
			merged = shifted;
		end else if (level_no_fetch[0]) begin
			merged = {word, shifted[0 +: hw_w]};
		end else begin
			merged = {shifted[2*hw_w +: hw_w], word};
		end
	end

	// the buffer empties on a redirect and stays empty until stale data is gone
	always_comb begin
		if (fs.flush || fs.flush_pending) begin
			buf_level_next = 2'd0;
		end else if (fs.fetch_data_vld && fs.unaligned_dph) begin
			buf_level_next = 2'd1;
		end else begin
			buf_level_next = buf_level + {fs.must_refill && fs.fetch_data_vld, 1'b0} - cir_use;
		end
	end

	// ==============================
	// registers
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
		end else begin
			buf_level <= buf_level_next;
			// cir itself holds at most two halfwords
			cir_vld <= buf_level_next & ~(buf_level_next >> 1);
		end
	end

	// contents are only looked at through the levels
	always_ff @(posedge clk) begin
		{hwbuf, cir} <= merged;
	end

	// predecode never takes halfwords the yard has not delivered
	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld);

endmodule

`default_nettype wire

/* verilog/predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module predecode (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] cir,
	input  logic [1:0]  cir_vld,
	output logic [1:0]  cir_use,
	input  logic [31:0] ext_jump_target,
	input  logic        ext_jump_vld,
	input  logic        jump_rdy,
	output logic [31:0] pd_jump_target,
	output logic        pd_jump_vld,
	output logic [31:0] instr,
	output logic [31:0] instr_pc,
	output logic        instr_vld,
	output logic        instr_is_c,
	input  logic        instr_stall
);

	rv_instr_pkg::instr_u word;
	logic is_32;
	logic have_instr;
	logic is_jump;
	logic ext_accept;
	logic pd_accept;
	logic consumed;
	logic [31:0] jal_off;
	logic [31:0] cj_off;
	logic [31:0] pc;

	assign word = cir;

	// length comes from the two low bits only so it is cheap to find
	assign is_32 = (cir[1:0] & rv_instr_pkg::instr_is_32) == rv_instr_pkg::instr_is_32;
	assign have_instr = is_32 ? cir_vld[1] : |cir_vld;

	// the same word read as JAL and as C.J
	assign is_jump = is_32 ? word.j.opcode == rv_instr_pkg::opc_jal
		: {word.c.lower.funct3, word.c.lower.op} == rv_instr_pkg::c_funct_j;

	// unscramble both immediates
	assign jal_off = {{12{word.j.imm[19]}}, word.j.imm[7:0], word.j.imm[8],
		word.j.imm[18:9], 1'b0};
	assign cj_off = {{21{word.c.lower.offset[10]}}, word.c.lower.offset[6],
		word.c.lower.offset[8:7], word.c.lower.offset[4], word.c.lower.offset[5],
		word.c.lower.offset[0], word.c.lower.offset[9], word.c.lower.offset[3:1], 1'b0};

	assign pd_jump_target = pc + (is_32 ? jal_off : cj_off);

	// only ask for a redirect when execute can take the jump in the same cycle
	assign pd_jump_vld = have_instr && is_jump && !instr_stall;

	// ==============================
	// handover to execute
	// ==============================

	assign ext_accept = ext_jump_vld && jump_rdy;
	assign pd_accept = pd_jump_vld && jump_rdy && !ext_jump_vld;

	// a jump waits for its own redirect
	// and nothing of the old stream goes out once execute redirects
	assign instr_vld = have_instr && !ext_accept && (!is_jump || pd_accept);
	assign consumed = instr_vld && !instr_stall;
	assign cir_use = consumed ? (is_32 ? 2'd2 : 2'd1) : 2'd0;

	assign instr = is_32 ? cir : {16'h0000, cir[15:0]};
	assign instr_pc = pc;
	assign instr_is_c = !is_32;

	// PC of the instruction at the bottom of cir
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= fe_bus_pkg::reset_vector;
		end else if (ext_accept) begin
			pc <= ext_jump_target;
		end else if (pd_accept) begin
			pc <= pd_jump_target;
		end else if (consumed) begin
			pc <= pc + (is_32 ? 32'd4 : 32'd2);
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_instr_pkg.sv */
`default_nettype none

// ==============================
// instruction encodings
// ==============================
package rv_instr_pkg;

	// major opcode of JAL in the low seven bits
	localparam logic [6:0] opc_jal = 7'b110_1111;

	// funct3 followed by the quadrant bits of C.J
	localparam logic [4:0] c_funct_j = 5'b101_01;

	// length rule
	// an instruction is 32 bits wide only when both low bits are set
	// every other pattern is a 16-bit compressed instruction
	localparam logic [1:0] instr_is_32 = 2'b11;

	// J-type layout of a full word
	// imm holds the scrambled offset bits 20, 10:1, 11 and 19:12
	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} j_view_t;

	// CJ layout of one halfword
	// offset holds offset bits 11, 4, 9:8, 10, 6, 7, 3:1 and 5
	typedef struct packed {
		logic [2:0]  funct3;
		logic [10:0] offset;
		logic [1:0]  op;
	} cj_hw_t;

	// compressed view of a full word
	// only the lower halfword belongs to the instruction
	typedef struct packed {
		logic [15:0] upper;
		cj_hw_t      lower;
	} c_view_t;

	// one cir word seen both ways
	// the low two bits tell which view is meaningful
	typedef union packed {
		j_view_t j;
		c_view_t c;
	} instr_u;

endpackage

`default_nettype wire
